// ==== id_2ri12.sv ====
`include "la_macros.svh"

module id_2ri12 import la_pkg::*; (
    input  logic [31:0] inst,
    output logic        inst_valid,
    output logic        reg_write_en,
    output alu_op_e     aluop,
    output logic [4:0]  reg1_read_addr,
    output logic [4:0]  reg_write_addr,
    output logic [31:0] imm
);
    assign reg1_read_addr = inst[9:5];
    assign reg_write_addr = inst[4:0];
    assign imm            = {{20{inst[21]}}, inst[21:10]};   // si12

    always_comb begin
        if (inst[31:22] == `LA_ADDIW_OPCODE) begin
            inst_valid   = 1'b1;
            reg_write_en = 1'b1;
            aluop        = alu_add;
        end else begin
            inst_valid   = 1'b0;
            reg_write_en = 1'b0;
            aluop        = alu_nop;
        end
    end
endmodule

// ==== id_3r.sv ====
`include "la_macros.svh"

module id_3r import la_pkg::*; (
    input  logic [31:0] pc,
    input  logic [31:0] inst,
    output logic        inst_valid,
    output logic        reg_write_en,
    output logic        reg1_read_en,
    output logic        reg2_read_en,
    output alu_op_e     aluop,
    output alu_sel_e    alusel,
    output logic [4:0]  reg1_read_addr,
    output logic [4:0]  reg2_read_addr,
    output logic [4:0]  reg_write_addr,
    output logic [31:0] imm
);
    logic [16:0] opcode;
    logic        aligned;

    assign opcode         = inst[31:15];
    assign aligned        = (pc[1:0] == 2'b00);
    assign reg1_read_addr = inst[9:5];     // rj
    assign reg2_read_addr = inst[14:10];   // rk

    always_comb begin
        case (opcode)
            `LA_ADDW_OPCODE:    aluop = alu_add;
            `LA_SUBW_OPCODE:    aluop = alu_sub;
            `LA_AND_OPCODE:     aluop = alu_and;
            `LA_OR_OPCODE:      aluop = alu_or;
            `LA_XOR_OPCODE:     aluop = alu_xor;
            `LA_NOR_OPCODE:     aluop = alu_nor;
            `LA_SLT_OPCODE:     aluop = alu_slt;
            `LA_SLTU_OPCODE:    aluop = alu_sltu;
            `LA_SLLW_OPCODE,
            `LA_SLLIW_OPCODE:   aluop = alu_sll;
            `LA_SRLW_OPCODE,
            `LA_SRLIW_OPCODE:   aluop = alu_srl;
            `LA_SRAW_OPCODE,
            `LA_SRAIW_OPCODE:   aluop = alu_sra;
            `LA_BREAK_OPCODE:   aluop = alu_break;
            `LA_SYSCALL_OPCODE: aluop = alu_syscall;
            `LA_IDLE_OPCODE:    aluop = alu_idle;
            default:            aluop = alu_nop;   // dbar, ibar, unknown
        endcase
    end

    always_comb begin
        inst_valid     = 1'b0;
        reg_write_en   = 1'b0;
        reg1_read_en   = 1'b0;
        reg2_read_en   = 1'b0;
        alusel         = alusel_nop;
        reg_write_addr = 5'b0;
        imm            = 32'b0;
        case (opcode)
            `LA_ADDW_OPCODE, `LA_SUBW_OPCODE, `LA_AND_OPCODE, `LA_OR_OPCODE,
            `LA_XOR_OPCODE, `LA_NOR_OPCODE, `LA_SLT_OPCODE, `LA_SLTU_OPCODE,
            `LA_SLLW_OPCODE, `LA_SRLW_OPCODE, `LA_SRAW_OPCODE: begin
                inst_valid     = 1'b1;
                reg_write_en   = 1'b1;
                reg1_read_en   = 1'b1;
                reg2_read_en   = 1'b1;
                alusel         = alusel_arith;
                reg_write_addr = inst[4:0];
            end
            `LA_SLLIW_OPCODE, `LA_SRLIW_OPCODE, `LA_SRAIW_OPCODE: begin
                inst_valid     = 1'b1;
                reg_write_en   = 1'b1;
                reg1_read_en   = 1'b1;
                alusel         = alusel_arith;
                reg_write_addr = inst[4:0];
                imm            = {27'b0, inst[14:10]};   // ui5
            end
            `LA_BREAK_OPCODE, `LA_SYSCALL_OPCODE, `LA_IDLE_OPCODE,
            `LA_DBAR_OPCODE, `LA_IBAR_OPCODE: begin
                inst_valid = 1'b1;
            end
            default: begin
                inst_valid = 1'b0;
            end
        endcase
        if (!aligned) begin
            inst_valid   = 1'b0;   // word not on a word boundary
            reg_write_en = 1'b0;
        end
    end
endmodule

// ==== inst_buffer.sv ====
`include "la_macros.svh"

module inst_buffer (
    input  logic          clk,
    input  logic          arst_n,
    inst_stream_if.sink   in_s,
    inst_stream_if.source out_s
);
    localparam int ptr_w = $clog2(`LA_IBUF_DEPTH);

    logic [31:0]      pc_mem   [`LA_IBUF_DEPTH];
    logic [31:0]      inst_mem [`LA_IBUF_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             push;
    logic             pop;

    assign push = in_s.valid && in_s.ready;
    assign pop  = out_s.valid && out_s.ready;

    // a pop frees the slot that a push fills when full
    assign in_s.ready  = (count != (ptr_w + 1)'(`LA_IBUF_DEPTH)) || out_s.ready;
    assign out_s.valid = (count != '0);
    assign out_s.pc    = pc_mem[rd_ptr];
    assign out_s.inst  = inst_mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]   <= in_s.pc;
            inst_mem[wr_ptr] <= in_s.inst;
        end
    end
endmodule

// ==== inst_stream_if.sv ====
interface inst_stream_if;
    logic        valid;
    logic        ready;
    logic [31:0] pc;
    logic [31:0] inst;

    modport source (
        output valid,
        output pc,
        output inst,
        input  ready
    );

    modport sink (
        input  valid,
        input  pc,
        input  inst,
        output ready
    );
endinterface

// ==== la_core_assert.sv ====
module la_core_assert (
    input logic        clk,
    input logic        arst_n,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic [31:0] wb_adr,
    input logic        wb_ack,
    input logic        retire_valid,
    input logic        retire_wen,
    input logic [4:0]  retire_waddr,
    input logic [5:0]  retire_ecode
);
    stb_in_cycle: assert property (@(posedge clk) disable iff (!arst_n) wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // address held until the slave acks
    adr_held: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
        else $error("wb_adr or wb_stb changed before wb_ack");

    wen_has_target: assert property (@(posedge clk) disable iff (!arst_n)
        retire_wen |-> (retire_valid && retire_waddr != 5'd0))
        else $error("retire_wen without retire_valid or with rd r0");

    no_write_on_exception: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid |-> !(retire_wen && retire_ecode != 6'd0))
        else $error("register write retired together with an exception code");
endmodule

bind la_core_top la_core_assert i_core_assert (
    .clk          (clk),
    .arst_n       (arst_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_adr       (wb_adr),
    .wb_ack       (wb_ack),
    .retire_valid (retire_valid),
    .retire_wen   (retire_wen),
    .retire_waddr (retire_waddr),
    .retire_ecode (retire_ecode)
);

// ==== la_core_top.sv ====
module la_core_top (
    input  logic        clk,
    input  logic        arst_n,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic [31:0] wb_adr,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack,
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic [31:0] retire_inst,
    output logic        retire_wen,
    output logic [4:0]  retire_waddr,
    output logic [31:0] retire_wdata,
    output logic [5:0]  retire_ecode
);
    inst_stream_if fetch_s ();   // fetch to buffer
    inst_stream_if exec_s ();    // buffer to execute

    la_fetch i_fetch (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_ack   (wb_ack),
        .wb_dat_i (wb_dat_i),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .out_s    (fetch_s)
    );

    inst_buffer i_inst_buffer (
        .clk    (clk),
        .arst_n (arst_n),
        .in_s   (fetch_s),
        .out_s  (exec_s)
    );

    la_exec i_exec (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_s         (exec_s),
        .retire_valid (retire_valid),
        .retire_wen   (retire_wen),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst),
        .retire_wdata (retire_wdata),
        .retire_waddr (retire_waddr),
        .retire_ecode (retire_ecode)
    );
endmodule

// ==== la_exec.sv ====
`include "la_macros.svh"

module la_exec import la_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    inst_stream_if.sink in_s,
    output logic        retire_valid,
    output logic        retire_wen,
    output logic [31:0] retire_pc,
    output logic [31:0] retire_inst,
    output logic [31:0] retire_wdata,
    output logic [4:0]  retire_waddr,
    output logic [5:0]  retire_ecode
);
    logic        halted;
    logic        fire;
    logic        d3_valid;
    logic        d3_wen;
    logic        d3_r1en;
    logic        d3_r2en;
    alu_op_e     d3_op;
    alu_sel_e    d3_sel;
    logic [4:0]  d3_ra1;
    logic [4:0]  d3_ra2;
    logic [4:0]  d3_wa;
    logic [31:0] d3_imm;
    logic        d2_valid;
    logic        d2_wen;
    alu_op_e     d2_op;
    logic [4:0]  d2_wa;
    logic [31:0] d2_imm;
    alu_op_e     op;
    logic        r1_en;
    logic [4:0]  ra1;
    logic [4:0]  waddr;
    logic        wen;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] result;
    logic [5:0]  ecode;
    logic [31:0] rf [32];

    id_3r i_id_3r (
        .pc             (in_s.pc),
        .inst           (in_s.inst),
        .inst_valid     (d3_valid),
        .reg_write_en   (d3_wen),
        .reg1_read_en   (d3_r1en),
        .reg2_read_en   (d3_r2en),
        .aluop          (d3_op),
        .alusel         (d3_sel),
        .reg1_read_addr (d3_ra1),
        .reg2_read_addr (d3_ra2),
        .reg_write_addr (d3_wa),
        .imm            (d3_imm)
    );

    id_2ri12 i_id_2ri12 (
        .inst           (in_s.inst),
        .inst_valid     (d2_valid),
        .reg_write_en   (d2_wen),
        .aluop          (d2_op),
        .reg1_read_addr (),
        .reg_write_addr (d2_wa),
        .imm            (d2_imm)
    );

    assign in_s.ready = !halted;
    assign fire       = in_s.valid && in_s.ready;

    // 3R decode wins, addi.w otherwise
    assign op    = d3_valid ? d3_op : d2_op;
    assign r1_en = d3_valid ? d3_r1en : d2_valid;
    assign ra1   = d3_ra1;   // rj field common to both formats
    assign waddr = d3_valid ? d3_wa : d2_wa;
    assign wen   = (d3_valid ? (d3_wen && d3_sel == alusel_arith) : d2_wen) && (waddr != 5'd0);

    assign ecode = !(d3_valid || d2_valid) ? `LA_ECODE_INE :
                   (op == alu_break)       ? `LA_ECODE_BRK :
                   (op == alu_syscall)     ? `LA_ECODE_SYS : `LA_ECODE_NONE;

    always_comb begin
        op1 = 32'b0;
        op2 = d3_valid ? d3_imm : d2_imm;
        if (r1_en && ra1 != 5'd0) begin
            op1 = rf[ra1];
        end
        if (d3_r2en) begin
            op2 = (d3_ra2 == 5'd0) ? 32'b0 : rf[d3_ra2];   // r0 reads as zero
        end
    end

    always_comb begin
        case (op)
            alu_add:  result = op1 + op2;
            alu_sub:  result = op1 - op2;
            alu_and:  result = op1 & op2;
            alu_or:   result = op1 | op2;
            alu_xor:  result = op1 ^ op2;
            alu_nor:  result = ~(op1 | op2);
            alu_slt:  result = {31'b0, $signed(op1) < $signed(op2)};
            alu_sltu: result = {31'b0, op1 < op2};
            alu_sll:  result = op1 << op2[4:0];
            alu_srl:  result = op1 >> op2[4:0];
            alu_sra:  result = $unsigned($signed(op1) >>> op2[4:0]);
            default:  result = 32'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted       <= 1'b0;
            retire_valid <= 1'b0;
            retire_wen   <= 1'b0;
        end else begin
            retire_valid <= fire;
            retire_wen   <= fire && wen;
            if (fire && op == alu_idle) begin
                halted <= 1'b1;   // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            retire_pc    <= in_s.pc;
            retire_inst  <= in_s.inst;
            retire_waddr <= waddr;
            retire_wdata <= result;
            retire_ecode <= ecode;
            if (wen) begin
                rf[waddr] <= result;
            end
        end
    end
endmodule

// ==== la_fetch.sv ====
`include "la_macros.svh"

module la_fetch import la_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          wb_ack,
    input  logic [31:0]   wb_dat_i,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic [31:0]   wb_adr,
    inst_stream_if.source out_s
);
    fetch_state_e state;
    logic [31:0]  pc;
    logic [31:0]  slot_pc;
    logic [31:0]  slot_inst;

    assign wb_stb = (state == fetch_request);
    assign wb_cyc = wb_stb;          // one beat per cycle
    assign wb_adr = pc;

    assign out_s.valid = (state == fetch_wait_full);   // slot holds a word
    assign out_s.pc    = slot_pc;
    assign out_s.inst  = slot_inst;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= fetch_idle;
            pc    <= `LA_RESET_PC;
        end else begin
            case (state)
                fetch_idle: begin
                    state <= fetch_request;
                end
                fetch_request: begin
                    if (wb_ack) begin
                        state <= fetch_wait_full;
                        pc    <= pc + 32'd4;
                    end
                end
                fetch_wait_full: begin
                    if (out_s.ready) begin
                        state <= fetch_request;   // slot drains on this edge
                    end
                end
                default: begin
                    state <= fetch_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wb_stb && wb_ack) begin
            slot_pc   <= pc;
            slot_inst <= wb_dat_i;
        end
    end
endmodule

// ==== la_macros.svh ====
`ifndef LA_MACROS_SVH
`define LA_MACROS_SVH

`define LA_RESET_PC         32'h1c00_0000
`define LA_IBUF_DEPTH       4               // power of two

// 3R, shift-immediate and system opcodes, inst[31:15]
`define LA_ADDW_OPCODE      17'h00020
`define LA_SUBW_OPCODE      17'h00022
`define LA_SLT_OPCODE       17'h00024
`define LA_SLTU_OPCODE      17'h00025
`define LA_NOR_OPCODE       17'h00028
`define LA_AND_OPCODE       17'h00029
`define LA_OR_OPCODE        17'h0002a
`define LA_XOR_OPCODE       17'h0002b
`define LA_SLLW_OPCODE      17'h0002e
`define LA_SRLW_OPCODE      17'h0002f
`define LA_SRAW_OPCODE      17'h00030
`define LA_BREAK_OPCODE     17'h00054
`define LA_SYSCALL_OPCODE   17'h00056
`define LA_SLLIW_OPCODE     17'h00081
`define LA_SRLIW_OPCODE     17'h00089
`define LA_SRAIW_OPCODE     17'h00091
`define LA_IDLE_OPCODE      17'h00c91
`define LA_DBAR_OPCODE      17'h070e4
`define LA_IBAR_OPCODE      17'h070e5

`define LA_ADDIW_OPCODE     10'h00a         // inst[31:22]

`define LA_ECODE_NONE       6'h00
`define LA_ECODE_SYS        6'h0b
`define LA_ECODE_BRK        6'h0c
`define LA_ECODE_INE        6'h0d

`endif

// ==== la_pkg.sv ====
package la_pkg;

    typedef enum logic [3:0] {
        alu_nop,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_break,
        alu_syscall,
        alu_idle
    } alu_op_e;

    typedef enum logic {
        alusel_nop,     // no register write
        alusel_arith
    } alu_sel_e;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_request,
        fetch_wait_full
    } fetch_state_e;

endpackage

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_la_core -f src.f -o tb_la_core
./obj_dir/tb_la_core

// ==== src.f ====
+incdir+.
la_pkg.sv
inst_stream_if.sv
la_fetch.sv
inst_buffer.sv
id_3r.sv
id_2ri12.sv
la_exec.sv
la_core_top.sv
la_core_assert.sv
tb_la_core.sv

// ==== tb_la_core.sv ====
`include "la_macros.svh"

module tb_la_core;
    typedef struct packed {
        logic [31:0] inst;
        logic        wen;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic [5:0]  ecode;
    } row_t;

    logic        clk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_i;
    logic        wb_ack;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [31:0] retire_inst;
    logic        retire_wen;
    logic [4:0]  retire_waddr;
    logic [31:0] retire_wdata;
    logic [5:0]  retire_ecode;
    row_t        rows [$];
    int unsigned ack_count = 0;

    la_core_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (wb_stb && wb_ack) begin
            ack_count <= ack_count + 1;   // accepted transfers
        end
    end

    function automatic logic [31:0] enc_3r(logic [16:0] opc, int rk, int rj, int rd);
        return {opc, 5'(rk), 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] enc_addi(int si, int rj, int rd);
        return {`LA_ADDIW_OPCODE, 12'(si), 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] enc_code(logic [16:0] opc);
        return {opc, 15'd0};
    endfunction

    task automatic add_row(logic [31:0] inst, logic wen, int waddr, logic [31:0] wdata,
                           logic [5:0] ecode);
        rows.push_back('{inst, wen, 5'(waddr), wdata, ecode});
    endtask

    task automatic load_program();
        add_row(enc_addi(5, 0, 1), 1'b1, 1, 32'h0000_0005, `LA_ECODE_NONE);
        add_row(enc_addi(-3, 0, 2), 1'b1, 2, 32'hffff_fffd, `LA_ECODE_NONE);
        add_row(enc_addi(35, 0, 3), 1'b1, 3, 32'h0000_0023, `LA_ECODE_NONE);
        add_row(enc_addi(-2048, 0, 4), 1'b1, 4, 32'hffff_f800, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_ADDW_OPCODE, 2, 1, 5), 1'b1, 5, 32'h0000_0002, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_SUBW_OPCODE, 2, 1, 6), 1'b1, 6, 32'h0000_0008, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_AND_OPCODE, 4, 2, 7), 1'b1, 7, 32'hffff_f800, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_OR_OPCODE, 4, 1, 8), 1'b1, 8, 32'hffff_f805, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_XOR_OPCODE, 2, 1, 9), 1'b1, 9, 32'hffff_fff8, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_NOR_OPCODE, 2, 1, 10), 1'b1, 10, 32'h0000_0002, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_SLT_OPCODE, 1, 2, 11), 1'b1, 11, 32'h0000_0001, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_SLTU_OPCODE, 1, 2, 12), 1'b1, 12, 32'h0000_0000, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_SLT_OPCODE, 2, 1, 13), 1'b1, 13, 32'h0000_0000, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_SLTU_OPCODE, 2, 1, 14), 1'b1, 14, 32'h0000_0001, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_SLLW_OPCODE, 3, 1, 15), 1'b1, 15, 32'h0000_0028, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_SRLW_OPCODE, 3, 2, 16), 1'b1, 16, 32'h1fff_ffff, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_SRAW_OPCODE, 3, 2, 17), 1'b1, 17, 32'hffff_ffff, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_SLLIW_OPCODE, 31, 1, 18), 1'b1, 18, 32'h8000_0000, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_SRLIW_OPCODE, 4, 4, 19), 1'b1, 19, 32'h0fff_ff80, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_SRAIW_OPCODE, 4, 4, 20), 1'b1, 20, 32'hffff_ff80, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_ADDW_OPCODE, 1, 1, 0), 1'b0, 0, 32'h0, `LA_ECODE_NONE);   // rd r0
        add_row(enc_3r(`LA_OR_OPCODE, 1, 0, 21), 1'b1, 21, 32'h0000_0005, `LA_ECODE_NONE);
        add_row(32'hffff_ffff, 1'b0, 0, 32'h0, `LA_ECODE_INE);
        add_row(enc_code(`LA_BREAK_OPCODE), 1'b0, 0, 32'h0, `LA_ECODE_BRK);
        add_row(enc_code(`LA_SYSCALL_OPCODE), 1'b0, 0, 32'h0, `LA_ECODE_SYS);
        add_row(enc_code(`LA_DBAR_OPCODE), 1'b0, 0, 32'h0, `LA_ECODE_NONE);
        add_row(enc_3r(`LA_ADDW_OPCODE, 6, 5, 22), 1'b1, 22, 32'h0000_000a, `LA_ECODE_NONE);
        add_row(enc_code(`LA_IDLE_OPCODE), 1'b0, 0, 32'h0, `LA_ECODE_NONE);
    endtask

    function automatic logic [31:0] word_at(logic [31:0] adr);
        int idx;
        idx = int'((adr - `LA_RESET_PC) >> 2);
        if (idx < rows.size()) begin
            return rows[idx].inst;
        end
        return enc_code(`LA_IDLE_OPCODE);   // past the program
    endfunction

    task automatic check_eq(string what, logic [31:0] act, logic [31:0] exp);
        if (act !== exp) begin
            $display("** Error at time %0t: %s is 0x%h, expected 0x%h", $time, what, act, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_quiet(string when);
        check_eq({when, " wb_cyc"}, 32'(wb_cyc), 32'd0);
        check_eq({when, " wb_stb"}, 32'(wb_stb), 32'd0);
        check_eq({when, " retire_valid"}, 32'(retire_valid), 32'd0);
        check_eq({when, " retire_wen"}, 32'(retire_wen), 32'd0);
    endtask

    // slave answers on the falling edge after 0 to 3 idle cycles
    initial begin : wb_slave
        logic [31:0] next_adr;
        int unsigned delay;
        void'($urandom(32'hdbfa_e268));
        next_adr = `LA_RESET_PC;
        forever begin
            @(negedge clk);
            if (wb_stb && arst_n) begin
                check_eq("wb_adr", wb_adr, next_adr);   // sequential fetch
                next_adr = next_adr + 32'd4;
                delay = $urandom % 4;
                repeat (delay) @(negedge clk);
                wb_dat_i = word_at(wb_adr);
                wb_ack   = 1'b1;
                @(negedge clk);
                wb_ack = 1'b0;
            end
        end
    end

    initial begin : stimulus
        int unsigned cycles;
        int unsigned ack_base;
        int          last_cyc_high;
        row_t        exp;
        arst_n   = 1'b0;
        wb_ack   = 1'b0;
        wb_dat_i = 32'h0;
        load_program();
        repeat (8) begin
            @(negedge clk);
            check_quiet("in reset");
        end
        arst_n = 1'b1;
        #1;
        check_quiet("after reset");
        @(negedge clk);
        check_eq("wb_stb one clock after reset", 32'(wb_stb), 32'd1);

        for (int i = 0; i < rows.size(); i++) begin
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
                if (cycles > 200) begin
                    $display("timeout: row %0d did not retire within 200 cycles", i);
                    $display("Errors found");
                    $fatal(1);
                end
            end while (!retire_valid);
            exp = rows[i];
            check_eq($sformatf("row %0d retire_pc", i), retire_pc, `LA_RESET_PC + 32'(4 * i));
            check_eq($sformatf("row %0d retire_inst", i), retire_inst, exp.inst);
            check_eq($sformatf("row %0d retire_wen", i), 32'(retire_wen), 32'(exp.wen));
            check_eq($sformatf("row %0d retire_ecode", i), 32'(retire_ecode), 32'(exp.ecode));
            if (exp.wen) begin
                check_eq($sformatf("row %0d retire_waddr", i), 32'(retire_waddr),
                         32'(exp.waddr));
                check_eq($sformatf("row %0d retire_wdata", i), retire_wdata, exp.wdata);
            end
        end

        // halted after idle, buffer fills and fetch parks
        ack_base      = ack_count;
        last_cyc_high = -1;
        for (int c = 0; c < 100; c++) begin
            @(negedge clk);
            check_eq("retire_valid while halted", 32'(retire_valid), 32'd0);
            if (wb_cyc) begin
                last_cyc_high = c;
            end
        end
        check_eq("acks after halt within buffer depth plus one",
                 32'(ack_count - ack_base <= `LA_IBUF_DEPTH + 1), 32'd1);
        check_eq("wb_cyc low over the last 20 halted cycles", 32'(last_cyc_high < 80), 32'd1);
        $display("No errors");
        $finish;
    end
endmodule
